//--- Makefile
# Verilator build and run for the Denise playfield testbench

VERILATOR ?= verilator
TOP       ?= denise_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
hw/denise_pkg.sv
hw/denise_ifs.sv
hw/denise_reg_decode.sv
hw/playfield_engine.sv
hw/color_output.sv
hw/denise_top.sv
testbench/denise_checker.sv
testbench/denise_tb.sv

//--- hw/color_output.sv
//////////////////////////////////////////////////
// Denise colour table and RGB output
// 32 x 12 CLUT, extra-half-brite, output register
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module color_output import denise_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  reg_write_if.sink        wr,
  pixel_if.dst             pix,
  output logic [RGB_W-1:0] rgb,
  output logic             pix_valid
);

  localparam int NUM_COMP = RGB_W / COMP_W;

  logic [RGB_W-1:0] clut [CLUT_DEPTH];
  logic [RGB_W-1:0] look_rgb;
  logic [RGB_W-1:0] half_rgb;

  //////////////////////////////////////////////////
  // Colour table
  //////////////////////////////////////////////////

  // COLORxx writes, upper nibble of the word dropped
  always_ff @(posedge clk) begin
    if (wr.wr_valid && wr.op == OP_COLOR) begin
      clut[wr.sel] <= wr.wdata[RGB_W-1:0];
    end
  end

  // Register read port
  assign wr.rd_rgb = clut[wr.sel];

  // Pixel lookup port
  assign look_rgb = clut[pix.clut_idx];

  // EHB, each of R, G, B shifted down one
  always_comb begin
    for (int c = 0; c < NUM_COMP; c++) begin
      half_rgb[c*COMP_W +: COMP_W] = look_rgb[c*COMP_W +: COMP_W] >> 1;
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rgb       <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= pix.pix_valid;
      if (!pix.pix_valid) begin
        // Black between lines
        rgb <= '0;
      end else if (pix.ehb) begin
        rgb <= half_rgb;
      end else begin
        rgb <= look_rgb;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/denise_ifs.sv
//////////////////////////////////////////////////
// Denise internal interfaces
// Register write bus and pixel stream
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

// Decoded register writes, fanned out to the datapath
interface reg_write_if import denise_pkg::*; ();

  logic                  wr_valid;
  reg_op_e               op;
  // Plane or colour number
  logic [CLUT_IDX_W-1:0] sel;
  logic [DATA_W-1:0]     wdata;
  // Current BPLCON state
  bplcon_t               cfg;
  // Colour entry at sel, for register reads
  logic [RGB_W-1:0]      rd_rgb;

  modport ctrl (
    output wr_valid, op, sel, wdata, cfg,
    input  rd_rgb
  );

  modport sink (
    input  wr_valid, op, sel, wdata, cfg,
    output rd_rgb
  );

endinterface

// One pixel per clk, no back-pressure
interface pixel_if import denise_pkg::*; ();

  logic                  pix_valid;
  logic [CLUT_IDX_W-1:0] clut_idx;
  // Extra-half-brite request
  logic                  ehb;

  modport src (output pix_valid, clut_idx, ehb);
  modport dst (input  pix_valid, clut_idx, ehb);

endinterface

`default_nettype wire

//--- hw/denise_pkg.sv
//////////////////////////////////////////////////
// Denise playfield shared definitions
// Register map, widths, decoded ops and BPLCON state
//////////////////////////////////////////////////

`default_nettype none

package denise_pkg;

  //////////////////////////////////////////////////
  // Bus and datapath widths
  //////////////////////////////////////////////////

  localparam int ADDR_W      = 9;
  localparam int DATA_W      = 16;
  localparam int RGB_W       = 12;
  // One colour component
  localparam int COMP_W      = 4;
  localparam int NUM_PLANES  = 6;
  localparam int PLANE_SEL_W = 3;
  localparam int CLUT_DEPTH  = 32;
  localparam int CLUT_IDX_W  = 5;
  // Top bit is the EHB bit
  localparam int PIX_IDX_W   = 6;
  localparam int LINE_PIXELS = 16;
  localparam int PIX_CNT_W   = 4;

  //////////////////////////////////////////////////
  // Register map, byte addresses
  //////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] BPLCON0_ADDR = 9'h100;
  localparam logic [ADDR_W-1:0] BPLCON2_ADDR = 9'h104;
  // BPL1DAT..BPL6DAT, stride 2
  localparam logic [ADDR_W-1:0] BPLDAT_BASE  = 9'h110;
  // COLOR00..COLOR31, stride 2
  localparam logic [ADDR_W-1:0] COLOR_BASE   = 9'h180;

  // Field positions in BPLCON0 / BPLCON2
  localparam int BPU_W      = 3;
  localparam int BPU_LSB    = 12;
  localparam int DBLPF_BIT  = 10;
  localparam int PF2PRI_BIT = 6;

  // Decoded register operation
  typedef enum logic [2:0] {
    OP_NONE    = 3'd0,
    OP_BPLCON0 = 3'd1,
    OP_BPLCON2 = 3'd2,
    OP_BPLDAT  = 3'd3,
    OP_COLOR   = 3'd4,
    OP_BAD     = 3'd5
  } reg_op_e;

  // Live playfield control state
  typedef struct packed {
    logic [BPU_W-1:0] bpu;
    logic             dblpf;
    logic             pf2pri;
  } bplcon_t;

endpackage

`default_nettype wire

//--- hw/denise_reg_decode.sv
//////////////////////////////////////////////////
// Denise APB register decoder
// Zero wait state slave, BPLCON state and read mux
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module denise_reg_decode import denise_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire [ADDR_W-1:0]   paddr,
  input  wire                psel,
  input  wire                penable,
  input  wire                pwrite,
  input  wire [DATA_W-1:0]   pwdata,
  output logic [DATA_W-1:0]  prdata,
  output logic               pready,
  output logic               pslverr,
  reg_write_if.ctrl          wr
);

  reg_op_e               op;
  logic [CLUT_IDX_W-1:0] sel;
  logic                  access;
  bplcon_t               cfg_q;
  logic [DATA_W-1:0]     rd_word;

  // Access phase of a transfer
  assign access = psel && penable;
  // No wait states
  assign pready = access;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  always_comb begin
    op  = OP_BAD;
    sel = '0;
    if (!psel) begin
      op = OP_NONE;
    end else if (paddr == BPLCON0_ADDR) begin
      op = OP_BPLCON0;
    end else if (paddr == BPLCON2_ADDR) begin
      op = OP_BPLCON2;
    end else if (paddr[ADDR_W-1:4] == BPLDAT_BASE[ADDR_W-1:4] && !paddr[0] &&
                 paddr[3:1] < PLANE_SEL_W'(NUM_PLANES)) begin
      // BPL1DAT..BPL6DAT, word aligned
      op  = OP_BPLDAT;
      sel = CLUT_IDX_W'(paddr[3:1]);
    end else if (paddr[ADDR_W-1:6] == COLOR_BASE[ADDR_W-1:6] && !paddr[0]) begin
      op  = OP_COLOR;
      sel = paddr[5:1];
    end
  end

  // Unmapped, or a read of a write-only data register
  assign pslverr = access && (op == OP_BAD || (!pwrite && op == OP_BPLDAT));

  //////////////////////////////////////////////////
  // Write strobe to the datapath
  //////////////////////////////////////////////////

  assign wr.wr_valid = access && pwrite && op != OP_NONE && op != OP_BAD;
  assign wr.op       = op;
  assign wr.sel      = sel;
  assign wr.wdata    = pwdata;
  assign wr.cfg      = cfg_q;

  // BPLCON0 and BPLCON2 fields
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (wr.wr_valid) begin
      if (op == OP_BPLCON0) begin
        cfg_q.bpu   <= pwdata[BPU_LSB +: BPU_W];
        cfg_q.dblpf <= pwdata[DBLPF_BIT];
      end else if (op == OP_BPLCON2) begin
        cfg_q.pf2pri <= pwdata[PF2PRI_BIT];
      end
    end
  end

  //////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (op)
      OP_BPLCON0: begin
        rd_word[BPU_LSB +: BPU_W] = cfg_q.bpu;
        rd_word[DBLPF_BIT]        = cfg_q.dblpf;
      end
      OP_BPLCON2: rd_word[PF2PRI_BIT] = cfg_q.pf2pri;
      // Colour entry straight from the table
      OP_COLOR:   rd_word[RGB_W-1:0]  = wr.rd_rgb;
      default:    rd_word = '0;
    endcase
  end

  // Only driven during a read access
  assign prdata = (access && !pwrite) ? rd_word : '0;

endmodule

`default_nettype wire

//--- hw/denise_top.sv
//////////////////////////////////////////////////
// Denise playfield top level
// APB registers in, 12-bit RGB pixels out
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module denise_top import denise_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  // APB slave
  input  wire [ADDR_W-1:0]   paddr,
  input  wire                psel,
  input  wire                penable,
  input  wire                pwrite,
  input  wire [DATA_W-1:0]   pwdata,
  output logic [DATA_W-1:0]  prdata,
  output logic               pready,
  output logic               pslverr,
  // Video
  output logic [RGB_W-1:0]   rgb,
  output logic               pix_valid
);

  // Register writes, decoder to datapath
  reg_write_if wr_bus ();
  // Pixel stream, engine to colour stage
  pixel_if     pix_bus ();

  //////////////////////////////////////////////////
  // Register decode
  //////////////////////////////////////////////////

  denise_reg_decode reg_decode_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .wr      (wr_bus.ctrl)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Shifters and priority, pixel 0 one cycle after the BPL1DAT write
  playfield_engine playfield_engine_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr_bus.sink),
    .pix   (pix_bus.src)
  );

  // CLUT lookup and output register
  color_output color_output_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr_bus.sink),
    .pix       (pix_bus.dst),
    .rgb       (rgb),
    .pix_valid (pix_valid)
  );

endmodule

`default_nettype wire

//--- hw/playfield_engine.sv
//////////////////////////////////////////////////
// Denise bitplane shifters and playfield priority
// Six plane latches, 16 pixel line, single/dual PF
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module playfield_engine import denise_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  reg_write_if.sink wr,
  pixel_if.src      pix
);

  localparam logic [PIX_CNT_W-1:0] LAST_PIX = PIX_CNT_W'(LINE_PIXELS - 1);

  // Planes 2..6, plane 1 goes straight into its shifter
  logic [DATA_W-1:0]     bpl_dat  [1:NUM_PLANES-1];
  logic [DATA_W-1:0]     load_dat [NUM_PLANES];
  logic [DATA_W-1:0]     shift_q  [NUM_PLANES];
  logic [NUM_PLANES-1:0] plane_en;
  logic [NUM_PLANES-1:0] plane_bit;
  logic [PIX_CNT_W-1:0]  cnt_q;
  logic                  active_q;
  logic                  load;
  logic [2:0]            pf1_val;
  logic [2:0]            pf2_val;
  logic [PIX_IDX_W-1:0]  pix_idx;

  // BPL1DAT write starts (or restarts) a line
  assign load = wr.wr_valid && wr.op == OP_BPLDAT && wr.sel == '0;

  //////////////////////////////////////////////////
  // Data latches and shifters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr.wr_valid && wr.op == OP_BPLDAT && wr.sel != '0) begin
      bpl_dat[wr.sel[PLANE_SEL_W-1:0]] <= wr.wdata;
    end
  end

  // Planes at or above BPU read as zero
  always_comb begin
    for (int p = 0; p < NUM_PLANES; p++) begin
      plane_en[p] = PLANE_SEL_W'(p) < wr.cfg.bpu;
    end
    load_dat[0] = wr.wdata & {DATA_W{plane_en[0]}};
    for (int p = 1; p < NUM_PLANES; p++) begin
      load_dat[p] = bpl_dat[p] & {DATA_W{plane_en[p]}};
    end
  end

  // MSB first, one pixel per clk
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= load_dat;
    end else if (active_q) begin
      for (int p = 0; p < NUM_PLANES; p++) begin
        shift_q[p] <= {shift_q[p][DATA_W-2:0], 1'b0};
      end
    end
  end

  // Pixel counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (load) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == LAST_PIX) begin
        active_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Playfield priority
  //////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < NUM_PLANES; p++) begin
      plane_bit[p] = shift_q[p][DATA_W-1];
    end
    // PF1 on odd planes, PF2 on even planes (1-based)
    pf1_val = {plane_bit[4], plane_bit[2], plane_bit[0]};
    pf2_val = {plane_bit[5], plane_bit[3], plane_bit[1]};

    if (!wr.cfg.dblpf) begin
      // Single playfield, bit 5 means EHB only with all six planes
      pix_idx = {plane_bit[5] && wr.cfg.bpu == BPU_W'(NUM_PLANES), plane_bit[4:0]};
    end else if (pf2_val != '0 && (pf1_val == '0 || wr.cfg.pf2pri)) begin
      // PF2 uses entries 8..15
      pix_idx = {3'b001, pf2_val};
    end else begin
      // PF1, or colour 0 when both are clear
      pix_idx = {3'b000, pf1_val};
    end
  end

  assign pix.pix_valid = active_q;
  assign pix.clut_idx  = pix_idx[CLUT_IDX_W-1:0];
  assign pix.ehb       = pix_idx[PIX_IDX_W-1];

endmodule

`default_nettype wire

//--- testbench/denise_checker.sv
//////////////////////////////////////////////////
// Denise playfield protocol checker
// Bound to the top level, APB and video rules
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module denise_checker import denise_pkg::*; (
  input wire              clk,
  input wire              rst_n,
  input wire [ADDR_W-1:0] paddr,
  input wire              psel,
  input wire              penable,
  input wire              pwrite,
  input wire              pready,
  input wire              pslverr,
  input wire              pix_valid,
  input wire [RGB_W-1:0]  rgb
);

  logic       bpl1_wr;
  // Cycles since the last BPL1DAT write, parks at 31
  logic [4:0] since_load;

  // Access cycle of a BPL1DAT write
  assign bpl1_wr = psel && penable && pwrite && paddr == BPLDAT_BASE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      since_load <= 5'd31;
    end else if (bpl1_wr) begin
      since_load <= 5'd1;
    end else if (since_load != 5'd31) begin
      since_load <= since_load + 5'd1;
    end
  end

  //////////////////////////////////////////////////
  // APB rules
  //////////////////////////////////////////////////

  // Zero wait states
  assert property (@(posedge clk) disable iff (!rst_n)
    psel && penable |-> pready)
    else $error("pready low during an APB access cycle");

  assert property (@(posedge clk) pslverr |-> psel && penable)
    else $error("pslverr high outside an access cycle");

  //////////////////////////////////////////////////
  // Video output rules
  //////////////////////////////////////////////////

  // Output register cleared by reset
  assert property (@(posedge clk) !rst_n |=> !pix_valid && rgb == '0)
    else $error("video output not idle after reset");

  // Black between lines
  assert property (@(posedge clk) disable iff (!rst_n)
    !pix_valid |-> rgb == '0)
    else $error("rgb not zero while pix_valid is low");

  // 16 valid cycles, from 2 to 17 cycles after the last load
  assert property (@(posedge clk) disable iff (!rst_n)
    since_load != 5'd1 |-> pix_valid == (since_load >= 5'd2 && since_load <= 5'd17))
    else $error("pix_valid window does not match the last BPL1DAT write");

  // Cycle after a load still shows the tail of any line in progress
  assert property (@(posedge clk) disable iff (!rst_n)
    since_load == 5'd1 |-> pix_valid == ($past(since_load) <= 5'd16))
    else $error("pix_valid wrong in the cycle after a BPL1DAT write");

endmodule

`default_nettype wire

//--- testbench/denise_tb.sv
//////////////////////////////////////////////////
// Denise playfield testbench
// APB stimulus, pixel reference model, timeout
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module denise_tb import denise_pkg::*; ();

  localparam int CLK_HALF       = 2;
  localparam int RESET_CYCLES   = 4;
  // Whole run needs well under 1000 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [RGB_W-1:0]  rgb;
  logic              pix_valid;

  // Reference model state
  logic [RGB_W-1:0]  clut_model  [CLUT_DEPTH];
  logic [DATA_W-1:0] plane_model [NUM_PLANES];
  int                bpu_model;
  logic              dblpf_model;
  logic              pf2pri_model;

  integer seed;
  int     cycles = 0;
  int     test_num = 0;
  int     test_errors = 0;
  int     total_errors = 0;
  int     failed_tests = 0;

  denise_top denise_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rgb       (rgb),
    .pix_valid (pix_valid)
  );

  bind denise_top denise_checker checker_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pready    (pready),
    .pslverr   (pslverr),
    .pix_valid (pix_valid),
    .rgb       (rgb)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // APB transfers, driven on the falling edge
  //////////////////////////////////////////////////

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    // Write lands on the rising edge in between
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    // Mid access, away from both edges
    #1;
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Checks and reference model
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic write_color(input int idx, input logic [DATA_W-1:0] data);
    write_reg(COLOR_BASE + ADDR_W'(2 * idx), data);
    // Top nibble is not stored
    clut_model[idx] = data[RGB_W-1:0];
  endtask

  task automatic set_mode(input int bpu, input logic dblpf, input logic pf2pri);
    logic [BPU_W-1:0] bpu_bits;
    bpu_bits = BPU_W'(bpu);
    // BPLCON0: BPU in 14:12, DBLPF at 10
    write_reg(BPLCON0_ADDR, {1'b0, bpu_bits, 1'b0, dblpf, 10'd0});
    // BPLCON2: PF2PRI at 6
    write_reg(BPLCON2_ADDR, {9'd0, pf2pri, 6'd0});
    bpu_model    = bpu;
    dblpf_model  = dblpf;
    pf2pri_model = pf2pri;
  endtask

  task automatic randomize_planes();
    for (int p = 0; p < NUM_PLANES; p++) begin
      plane_model[p] = DATA_W'($random(seed));
    end
  endtask

  // Planes 2..6 first, BPL1DAT last starts the line
  task automatic load_line();
    for (int p = 1; p < NUM_PLANES; p++) begin
      write_reg(BPLDAT_BASE + ADDR_W'(2 * p), plane_model[p]);
    end
    write_reg(BPLDAT_BASE, plane_model[0]);
  endtask

  function automatic logic [RGB_W-1:0] expected_pixel(input int pos);
    logic [NUM_PLANES-1:0] bits;
    logic [2:0]            pf1;
    logic [2:0]            pf2;
    logic [CLUT_IDX_W-1:0] idx;
    logic [RGB_W-1:0]      c;
    // Planes at or above BPU read as zero, MSB is pixel 0
    for (int p = 0; p < NUM_PLANES; p++) begin
      bits[p] = (p < bpu_model) ? plane_model[p][DATA_W-1-pos] : 1'b0;
    end
    if (!dblpf_model) begin
      c = clut_model[bits[4:0]];
      // Extra-half-brite
      if (bpu_model == NUM_PLANES && bits[5]) begin
        c = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
      end
    end else begin
      pf1 = {bits[4], bits[2], bits[0]};
      pf2 = {bits[5], bits[3], bits[1]};
      // Non-zero playfield wins
      if (pf1 == 3'd0 && pf2 == 3'd0) begin
        idx = 5'd0;
      end else if (pf1 == 3'd0) begin
        idx = 5'd8 + 5'(pf2);
      end else if (pf2 == 3'd0) begin
        idx = 5'(pf1);
      end else if (pf2pri_model) begin
        // Both set, PF2PRI picks playfield 2
        idx = 5'd8 + 5'(pf2);
      end else begin
        idx = 5'(pf1);
      end
      c = clut_model[idx];
    end
    return c;
  endfunction

  // Call right after the BPL1DAT write returns
  task automatic check_line();
    for (int i = 0; i < LINE_PIXELS; i++) begin
      @(negedge clk);
      check_value($sformatf("pix_valid pixel %0d", i), {15'd0, pix_valid}, 16'd1);
      check_value($sformatf("rgb pixel %0d", i), {4'h0, rgb}, {4'h0, expected_pixel(i)});
    end
    @(negedge clk);
    check_value("pix_valid after line", {15'd0, pix_valid}, 16'd0);
    check_value("rgb after line", {4'h0, rgb}, 16'd0);
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (test_errors == 0) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_num, name, test_errors);
      failed_tests++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [DATA_W-1:0] rdata;
    logic              rerr;
    seed    = 32'h23b6_1152;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Fill the whole CLUT, read it back, then the two error cases
    for (int i = 0; i < CLUT_DEPTH; i++) begin
      write_color(i, DATA_W'($random(seed)));
    end
    for (int i = 0; i < CLUT_DEPTH; i++) begin
      read_reg(COLOR_BASE + ADDR_W'(2 * i), rdata, rerr);
      check_value($sformatf("prdata COLOR%0d", i), rdata, {4'h0, clut_model[i]});
      check_value($sformatf("pslverr COLOR%0d", i), {15'd0, rerr}, 16'd0);
    end
    read_reg(9'h0f0, rdata, rerr);
    check_value("pslverr unmapped read", {15'd0, rerr}, 16'd1);
    read_reg(BPLDAT_BASE, rdata, rerr);
    check_value("pslverr BPL1DAT read", {15'd0, rerr}, 16'd1);
    finish_test("colour table readback");

    for (int bpu = 1; bpu < NUM_PLANES; bpu++) begin
      set_mode(bpu, 1'b0, 1'b0);
      randomize_planes();
      load_line();
      check_line();
    end
    finish_test("single playfield, 1 to 5 planes");

    // Second line flips plane 6, so every pixel sees both EHB cases
    set_mode(NUM_PLANES, 1'b0, 1'b0);
    randomize_planes();
    load_line();
    check_line();
    plane_model[5] = ~plane_model[5];
    load_line();
    check_line();
    finish_test("single playfield, extra-half-brite");

    for (int pri = 0; pri < 2; pri++) begin
      set_mode(NUM_PLANES, 1'b1, pri[0]);
      randomize_planes();
      load_line();
      check_line();
    end
    finish_test("dual playfield priority");

    // Restart mid line
    set_mode(4, 1'b0, 1'b0);
    randomize_planes();
    load_line();
    repeat (5) @(negedge clk);
    // Only BPL1DAT again, planes 2..6 stay latched
    plane_model[0] = DATA_W'($random(seed));
    write_reg(BPLDAT_BASE, plane_model[0]);
    check_line();
    finish_test("line restart");

    $display("Tests run: %0d, failed: %0d, errors: %0d", test_num, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
